// ==== source/eth_rx_pkg.sv ====
`default_nettype none

package eth_rx_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes and constants

	// Word buffer, about 2 KiB of frame data
	localparam int buf_words  = 512;
	localparam int buf_addr_w = 9;

	// Committed frame descriptors waiting for the reader
	localparam int desc_depth = 4;
	localparam int desc_ptr_w = 2;

	// Framing bytes as seen on GMII
	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte      = 8'hD5;

	// Reflected CRC-32 polynomial and its seed
	localparam logic [31:0] crc_poly = 32'hEDB88320;
	localparam logic [31:0] crc_seed = 32'hFFFFFFFF;

	//////////////////////////////////////////////////////////////////////
	// Types shared between modules

	// dvalid paces 10/100 operation, one byte per strobe
	typedef struct packed {
		logic       dvalid;
		logic       en;
		logic       er;
		logic [7:0] data;
	} gmii_bus_t;

	typedef enum logic [2:0] {
		idle,
		drop,
		preamble,
		frame_data,
		crc_check
	} rx_state_t;

	// MAC output, every field a one-cycle pulse
	typedef struct packed {
		logic        start;
		logic        data_valid;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
		logic        commit;
		logic        drop;
	} mac_word_t;

	// One access request towards the word buffer
	typedef struct packed {
		logic                  req;
		logic                  we;
		logic [buf_addr_w-1:0] addr;
		logic [31:0]           wdata;
	} buf_req_t;

	typedef struct packed {
		logic [buf_addr_w-1:0] start_addr;
		logic [buf_addr_w:0]   word_count;
		logic [2:0]            last_bytes;
	} frame_desc_t;

	typedef struct packed {
		logic        valid;
		logic        sof;
		logic        eof;
		logic [2:0]  bytes_valid;
		logic [31:0] data;
	} host_word_t;

	typedef struct packed {
		logic [15:0] frames_ok;
		logic [15:0] frames_dropped;
	} rx_stats_t;

endpackage

`default_nettype wire

// ==== source/crc32_ethernet.sv ====
`default_nettype none

module crc32_ethernet (
	input  logic        gmii_rx_clk,
	input  logic        arst_n,
	input  logic        reset,
	input  logic        update,
	input  logic [7:0]  din,
	output logic [31:0] crc_flipped
);

	logic [31:0] crc;
	logic [31:0] crc_next;

	// One byte per update, LSB first as on the wire
	always_comb begin
		crc_next = crc;
		for (int i = 0; i < 8; i++) begin
			crc_next = {1'b0, crc_next[31:1]}
				^ (eth_rx_pkg::crc_poly & {32{crc_next[0] ^ din[i]}});
		end
	end

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc <= eth_rx_pkg::crc_seed;
		end else if (reset) begin
			crc <= eth_rx_pkg::crc_seed;
		end else if (update) begin
			crc <= crc_next;
		end
	end

	// Complemented FCS, first byte on the wire in the top byte
	assign crc_flipped = ~{crc[7:0], crc[15:8], crc[23:16], crc[31:24]};

endmodule

`default_nettype wire

// ==== source/gmii_rx_mac.sv ====
`default_nettype none

module gmii_rx_mac (
	input  logic                  gmii_rx_clk,
	input  logic                  arst_n,
	input  eth_rx_pkg::gmii_bus_t gmii_rx,
	output eth_rx_pkg::mac_word_t mac_out
);

	eth_rx_pkg::rx_state_t state;

	// Hold register keeps the newest four bytes, which may be the FCS
	logic [31:0] hold;
	logic [2:0]  hold_cnt;

	// Bytes leaving the hold register are packed big-endian
	logic [23:0] pack;
	logic [1:0]  pack_cnt;

	logic        got_word;
	logic        frame_err;
	logic        byte_in;
	logic        byte_out;
	logic        frame_end;
	logic        crc_reset;
	logic [31:0] crc_fcs;

	// Registered output pulses and word data
	logic        start_q;
	logic        dv_q;
	logic [2:0]  bv_q;
	logic [31:0] word_data;
	logic        commit_q;
	logic        drop_q;

	assign byte_in   = gmii_rx.dvalid && gmii_rx.en && (state == eth_rx_pkg::frame_data);
	assign byte_out  = byte_in && (hold_cnt == 3'd4);
	assign frame_end = gmii_rx.dvalid && !gmii_rx.en && (state == eth_rx_pkg::frame_data);
	assign crc_reset = (state == eth_rx_pkg::preamble);

	// CRC sees only bytes pushed out of the hold register
	crc32_ethernet u_crc (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.reset       (crc_reset),
		.update      (byte_out),
		.din         (hold[31:24]),
		.crc_flipped (crc_fcs)
	);

	//////////////////////////////////////////////////////////////////////
	// Framing FSM

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= eth_rx_pkg::idle;
			hold_cnt  <= 3'd0;
			pack_cnt  <= 2'd0;
			got_word  <= 1'b0;
			frame_err <= 1'b0;
			start_q   <= 1'b0;
			dv_q      <= 1'b0;
			bv_q      <= 3'd0;
			commit_q  <= 1'b0;
			drop_q    <= 1'b0;
		end else begin
			start_q  <= 1'b0;
			dv_q     <= 1'b0;
			bv_q     <= 3'd0;
			commit_q <= 1'b0;
			drop_q   <= 1'b0;
			if (gmii_rx.dvalid) begin
				case (state)
					eth_rx_pkg::idle: begin
						// er outside a frame is ignored
						if (gmii_rx.en) begin
							if (gmii_rx.data == eth_rx_pkg::preamble_byte && !gmii_rx.er)
								state <= eth_rx_pkg::preamble;
							else
								state <= eth_rx_pkg::drop;
						end
					end
					eth_rx_pkg::preamble: begin
						// Truncated in the preamble, nothing was announced
						if (!gmii_rx.en) begin
							state <= eth_rx_pkg::idle;
						end else if (gmii_rx.er) begin
							state <= eth_rx_pkg::drop;
						end else if (gmii_rx.data == eth_rx_pkg::sfd_byte) begin
							start_q   <= 1'b1;
							state     <= eth_rx_pkg::frame_data;
							hold_cnt  <= 3'd0;
							pack_cnt  <= 2'd0;
							got_word  <= 1'b0;
							frame_err <= 1'b0;
						end else if (gmii_rx.data != eth_rx_pkg::preamble_byte) begin
							state <= eth_rx_pkg::drop;
						end
					end
					eth_rx_pkg::frame_data: begin
						if (!gmii_rx.en) begin
							state <= eth_rx_pkg::crc_check;
							// Flush a partial word
							if (pack_cnt != 2'd0) begin
								dv_q <= 1'b1;
								bv_q <= {1'b0, pack_cnt};
							end
						end else begin
							if (gmii_rx.er)
								frame_err <= 1'b1;
							if (hold_cnt != 3'd4) begin
								hold_cnt <= hold_cnt + 3'd1;
							end else begin
								// Counter wraps to zero after a full word
								pack_cnt <= pack_cnt + 2'd1;
								if (pack_cnt == 2'd3) begin
									dv_q     <= 1'b1;
									bv_q     <= 3'd4;
									got_word <= 1'b1;
								end
							end
						end
					end
					eth_rx_pkg::crc_check: begin
						state <= eth_rx_pkg::idle;
						// Payload under four bytes never fills a word
						if (got_word && !frame_err && crc_fcs == hold)
							commit_q <= 1'b1;
						else
							drop_q <= 1'b1;
					end
					eth_rx_pkg::drop: begin
						if (!gmii_rx.en)
							state <= eth_rx_pkg::idle;
					end
					default: state <= eth_rx_pkg::idle;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data path

	always_ff @(posedge gmii_rx_clk) begin
		if (byte_in)
			hold <= {hold[23:0], gmii_rx.data};
		if (byte_out) begin
			pack <= {pack[15:0], hold[31:24]};
			if (pack_cnt == 2'd3)
				word_data <= {pack, hold[31:24]};
		end
		// Partial word, left aligned
		if (frame_end) begin
			case (pack_cnt)
				2'd1:    word_data <= {pack[7:0], 24'h0};
				2'd2:    word_data <= {pack[15:0], 16'h0};
				2'd3:    word_data <= {pack[23:0], 8'h0};
				default: word_data <= word_data;
			endcase
		end
	end

	always_comb begin
		mac_out.start       = start_q;
		mac_out.data_valid  = dv_q;
		mac_out.bytes_valid = bv_q;
		mac_out.data        = word_data;
		mac_out.commit      = commit_q;
		mac_out.drop        = drop_q;
	end

endmodule

`default_nettype wire

// ==== source/rx_frame_writer.sv ====
`default_nettype none

module rx_frame_writer (
	input  logic                                gmii_rx_clk,
	input  logic                                arst_n,
	input  eth_rx_pkg::mac_word_t               mac_in,
	input  logic [eth_rx_pkg::buf_addr_w:0]     rd_ptr,
	input  logic                                desc_full,
	output eth_rx_pkg::buf_req_t                wr_req,
	output logic                                desc_push,
	output eth_rx_pkg::frame_desc_t             desc,
	output eth_rx_pkg::rx_stats_t               stats
);

	// Pointers carry one extra wrap bit
	logic [eth_rx_pkg::buf_addr_w:0]   commit_ptr;
	logic [eth_rx_pkg::buf_addr_w:0]   work_ptr;
	logic [eth_rx_pkg::buf_addr_w:0]   used;
	logic                              space_ok;
	logic                              overrun;
	logic                              good_commit;
	logic [2:0]                        last_bytes;
	logic                              wr_valid;
	logic [eth_rx_pkg::buf_addr_w-1:0] wr_addr;
	logic [31:0]                       wr_data;

	// Buffer full when the working pointer is a whole buffer ahead
	assign used        = work_ptr - rd_ptr;
	assign space_ok    = !used[eth_rx_pkg::buf_addr_w];
	assign good_commit = mac_in.commit && !overrun && !desc_full;

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			commit_ptr <= '0;
			work_ptr   <= '0;
			overrun    <= 1'b0;
			wr_valid   <= 1'b0;
			desc_push  <= 1'b0;
			stats      <= '0;
		end else begin
			wr_valid  <= 1'b0;
			desc_push <= 1'b0;
			if (mac_in.start)
				overrun <= 1'b0;
			// After an overrun the rest of the frame is discarded
			if (mac_in.data_valid && !overrun) begin
				if (space_ok) begin
					wr_valid <= 1'b1;
					work_ptr <= work_ptr + 1'b1;
				end else begin
					overrun  <= 1'b1;
					work_ptr <= commit_ptr;
				end
			end
			if (good_commit) begin
				desc_push       <= 1'b1;
				commit_ptr      <= work_ptr;
				stats.frames_ok <= stats.frames_ok + 16'd1;
			end else if (mac_in.commit || mac_in.drop) begin
				// Rewind over the partial frame
				work_ptr             <= commit_ptr;
				stats.frames_dropped <= stats.frames_dropped + 16'd1;
			end
		end
	end

	always_ff @(posedge gmii_rx_clk) begin
		if (mac_in.data_valid) begin
			wr_addr    <= work_ptr[eth_rx_pkg::buf_addr_w-1:0];
			wr_data    <= mac_in.data;
			last_bytes <= mac_in.bytes_valid;
		end
		if (good_commit) begin
			desc.start_addr <= commit_ptr[eth_rx_pkg::buf_addr_w-1:0];
			desc.word_count <= work_ptr - commit_ptr;
			desc.last_bytes <= last_bytes;
		end
	end

	always_comb begin
		wr_req.req   = wr_valid;
		wr_req.we    = wr_valid;
		wr_req.addr  = wr_addr;
		wr_req.wdata = wr_data;
	end

endmodule

`default_nettype wire

// ==== source/rx_frame_reader.sv ====
`default_nettype none

module rx_frame_reader (
	input  logic                            gmii_rx_clk,
	input  logic                            arst_n,
	input  logic                            desc_push,
	input  eth_rx_pkg::frame_desc_t         desc,
	input  logic                            gnt_rd,
	input  logic [31:0]                     rdata,
	output eth_rx_pkg::buf_req_t            rd_req,
	output logic [eth_rx_pkg::buf_addr_w:0] rd_ptr,
	output logic                            desc_full,
	output eth_rx_pkg::host_word_t          host_out
);

	eth_rx_pkg::frame_desc_t queue [eth_rx_pkg::desc_depth];

	logic [eth_rx_pkg::desc_ptr_w-1:0] q_wr;
	logic [eth_rx_pkg::desc_ptr_w-1:0] q_rd;
	logic [eth_rx_pkg::desc_ptr_w:0]   q_count;
	logic                              q_pop;

	// Read sequencer state
	logic                              busy;
	logic                              first;
	logic [eth_rx_pkg::buf_addr_w-1:0] cur_addr;
	logic [eth_rx_pkg::buf_addr_w:0]   words_left;
	logic [eth_rx_pkg::buf_addr_w:0]   frame_words;
	logic [2:0]                        last_bytes;
	logic                              rd_fire;
	logic                              rd_last;

	// Tags for the word coming back from the buffer
	logic                              p_valid;
	logic                              p_sof;
	logic                              p_eof;
	logic [2:0]                        p_bytes;

	assign desc_full = (q_count == (eth_rx_pkg::desc_ptr_w + 1)'(eth_rx_pkg::desc_depth));
	assign q_pop     = !busy && (q_count != '0);
	assign rd_fire   = busy && gnt_rd;
	assign rd_last   = (words_left == 1);

	always_ff @(posedge gmii_rx_clk) begin
		if (desc_push)
			queue[q_wr] <= desc;
	end

	always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			q_wr    <= '0;
			q_rd    <= '0;
			q_count <= '0;
			busy    <= 1'b0;
			first   <= 1'b0;
			rd_ptr  <= '0;
			p_valid <= 1'b0;
			p_sof   <= 1'b0;
			p_eof   <= 1'b0;
		end else begin
			if (desc_push)
				q_wr <= q_wr + 1'b1;
			if (q_pop)
				q_rd <= q_rd + 1'b1;
			if (desc_push && !q_pop)
				q_count <= q_count + 1'b1;
			else if (!desc_push && q_pop)
				q_count <= q_count - 1'b1;
			p_valid <= rd_fire;
			p_sof   <= rd_fire && first;
			p_eof   <= rd_fire && rd_last;
			if (q_pop) begin
				busy  <= 1'b1;
				first <= 1'b1;
			end else if (rd_fire) begin
				first <= 1'b0;
				// Space is released only once the whole frame is out
				if (rd_last) begin
					busy   <= 1'b0;
					rd_ptr <= rd_ptr + frame_words;
				end
			end
		end
	end

	always_ff @(posedge gmii_rx_clk) begin
		if (q_pop) begin
			cur_addr    <= queue[q_rd].start_addr;
			words_left  <= queue[q_rd].word_count;
			frame_words <= queue[q_rd].word_count;
			last_bytes  <= queue[q_rd].last_bytes;
		end else if (rd_fire) begin
			cur_addr   <= cur_addr + 1'b1;
			words_left <= words_left - 1'b1;
		end
		p_bytes <= rd_last ? last_bytes : 3'd4;
	end

	always_comb begin
		rd_req.req   = busy;
		rd_req.we    = 1'b0;
		rd_req.addr  = cur_addr;
		rd_req.wdata = '0;
	end

	always_comb begin
		host_out.valid       = p_valid;
		host_out.sof         = p_sof;
		host_out.eof         = p_eof;
		host_out.bytes_valid = p_bytes;
		host_out.data        = rdata;
	end

endmodule

`default_nettype wire

// ==== source/buffer_arbiter.sv ====
`default_nettype none

module buffer_arbiter (
	input  logic                 gmii_rx_clk,
	input  eth_rx_pkg::buf_req_t wr_req,
	input  eth_rx_pkg::buf_req_t rd_req,
	output logic                 gnt_rd,
	output logic [31:0]          rdata
);

	logic [31:0] mem [eth_rx_pkg::buf_words];

	// Single port, shared by both peers
	logic [eth_rx_pkg::buf_addr_w-1:0] port_addr;
	logic                              port_we;
	logic [31:0]                       port_wdata;

	// Writer has fixed priority and never waits
	assign gnt_rd = rd_req.req && !wr_req.req;

	always_comb begin
		if (wr_req.req) begin
			port_addr  = wr_req.addr;
			port_we    = wr_req.we;
			port_wdata = wr_req.wdata;
		end else begin
			port_addr  = rd_req.addr;
			port_we    = rd_req.req && rd_req.we;
			port_wdata = rd_req.wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Word RAM

	// Registered read, valid the cycle after a granted read
	always_ff @(posedge gmii_rx_clk) begin
		if (port_we)
			mem[port_addr] <= port_wdata;
		rdata <= mem[port_addr];
	end

endmodule

`default_nettype wire

// ==== source/eth_rx_top.sv ====
`default_nettype none

module eth_rx_top (
	input  logic                   gmii_rx_clk,
	input  logic                   arst_n,
	input  eth_rx_pkg::gmii_bus_t  gmii_rx,
	output eth_rx_pkg::host_word_t host_out,
	output eth_rx_pkg::rx_stats_t  stats
);

	eth_rx_pkg::mac_word_t           mac_word;
	eth_rx_pkg::buf_req_t            wr_req;
	eth_rx_pkg::buf_req_t            rd_req;
	eth_rx_pkg::frame_desc_t         desc;
	logic                            desc_push;
	logic                            desc_full;
	logic [eth_rx_pkg::buf_addr_w:0] rd_ptr;
	logic                            gnt_rd;
	logic [31:0]                     rdata;

	// GMII framing and FCS check
	gmii_rx_mac u_mac (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.gmii_rx     (gmii_rx),
		.mac_out     (mac_word)
	);

	rx_frame_writer u_writer (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.mac_in      (mac_word),
		.rd_ptr      (rd_ptr),
		.desc_full   (desc_full),
		.wr_req      (wr_req),
		.desc_push   (desc_push),
		.desc        (desc),
		.stats       (stats)
	);

	// Host side playback
	rx_frame_reader u_reader (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.desc_push   (desc_push),
		.desc        (desc),
		.gnt_rd      (gnt_rd),
		.rdata       (rdata),
		.rd_req      (rd_req),
		.rd_ptr      (rd_ptr),
		.desc_full   (desc_full),
		.host_out    (host_out)
	);

	buffer_arbiter u_arbiter (
		.gmii_rx_clk (gmii_rx_clk),
		.wr_req      (wr_req),
		.rd_req      (rd_req),
		.gnt_rd      (gnt_rd),
		.rdata       (rdata)
	);

endmodule

`default_nettype wire

// ==== test/tb_eth_rx.sv ====
`default_nettype none

module tb_eth_rx;

	// Kinds of frame the generator can put on the wire
	typedef enum int {
		fk_good,
		fk_bad_fcs,
		fk_error,
		fk_bad_pre,
		fk_short,
		fk_runt,
		fk_trunc
	} frame_kind_t;

	logic                   gmii_rx_clk = 1'b0;
	logic                   arst_n;
	eth_rx_pkg::gmii_bus_t  gmii_rx;
	eth_rx_pkg::host_word_t host_out;
	eth_rx_pkg::rx_stats_t  stats;

	// Reference model state
	eth_rx_pkg::host_word_t exp_words[$];
	string                  exp_names[$];
	eth_rx_pkg::rx_stats_t  exp_stats;
	int                     seed = 7374;
	int                     error_count = 0;

	// Test lengths that also size the watchdog
	int full_frames   = 24;
	int fcs_pairs     = 6;
	int err_rounds    = 2;
	int sparse_frames = 6;
	int burst_frames  = 32;
	// Preamble and SFD, longest payload, FCS, widest gap
	int max_wire_bytes = 124;

	always #50 gmii_rx_clk = ~gmii_rx_clk;

	eth_rx_top u_eth_rx_top (
		.gmii_rx_clk (gmii_rx_clk),
		.arst_n      (arst_n),
		.gmii_rx     (gmii_rx),
		.host_out    (host_out),
		.stats       (stats)
	);

	//////////////////////////////////////////////////////////////////////
	// Reference model

	// Reflected Ethernet CRC-32 with all-ones seed and complemented result
	function automatic logic [31:0] crc32_of(input logic [7:0] bytes[$]);
		logic [31:0] c;
		c = 32'hFFFF_FFFF;
		foreach (bytes[i]) begin
			c = c ^ {24'h0, bytes[i]};
			for (int k = 0; k < 8; k++)
				c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
		end
		return ~c;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		r = r & 32'h7FFF_FFFF;
		return lo + (r % (hi - lo + 1));
	endfunction

	// Big-endian words with the last word left aligned and zero filled
	task automatic push_expected(input logic [7:0] payload[$], input string name);
		eth_rx_pkg::host_word_t hw;
		int nw;
		int idx;
		nw = (payload.size() + 3) / 4;
		for (int w = 0; w < nw; w++) begin
			hw             = '0;
			hw.valid       = 1'b1;
			hw.sof         = (w == 0);
			hw.eof         = (w == nw - 1);
			hw.bytes_valid = (w == nw - 1) ? 3'(payload.size() - 4 * w) : 3'd4;
			for (int b = 0; b < 4; b++) begin
				idx     = 4 * w + b;
				hw.data = {hw.data[23:0], (idx < payload.size()) ? payload[idx] : 8'h00};
			end
			exp_words.push_back(hw);
			exp_names.push_back(name);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checks

	function automatic string word_text(input eth_rx_pkg::host_word_t w);
		return $sformatf("valid=%0b sof=%0b eof=%0b bytes=%0d data=%h",
			w.valid, w.sof, w.eof, w.bytes_valid, w.data);
	endfunction

	task automatic abort_run();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_host_word(input string name, input eth_rx_pkg::host_word_t want,
			input eth_rx_pkg::host_word_t got);
		if (got !== want) begin
			error_count++;
			$display("** Error %s: expected %s, actual %s", name, word_text(want),
				word_text(got));
			abort_run();
		end
	endtask

	task automatic compare_stats(input string name, input eth_rx_pkg::rx_stats_t want,
			input eth_rx_pkg::rx_stats_t got);
		if (got !== want) begin
			error_count++;
			$display("** Error %s: expected ok=%0d dropped=%0d, actual ok=%0d dropped=%0d",
				name, want.frames_ok, want.frames_dropped, got.frames_ok,
				got.frames_dropped);
			abort_run();
		end
	endtask

	task automatic check_host_word(input eth_rx_pkg::host_word_t got);
		if (exp_words.size() == 0) begin
			error_count++;
			$display("The host port delivered a word that no sent frame accounts for: %s",
				word_text(got));
			abort_run();
		end else begin
			compare_host_word(exp_names.pop_front(), exp_words.pop_front(), got);
		end
	endtask

	// Host words are registered, so values seen at the edge are settled
	always @(posedge gmii_rx_clk) begin
		if (arst_n && host_out.valid)
			check_host_word(host_out);
	end

	//////////////////////////////////////////////////////////////////////
	// Frame generator

	// One byte per dvalid while slow links idle for the rest of the spacing
	task automatic drive_byte(input logic en, input logic er, input logic [7:0] data,
			input int spacing);
		@(posedge gmii_rx_clk);
		gmii_rx.dvalid <= 1'b1;
		gmii_rx.en     <= en;
		gmii_rx.er     <= er;
		gmii_rx.data   <= data;
		for (int i = 1; i < spacing; i++) begin
			@(posedge gmii_rx_clk);
			gmii_rx.dvalid <= 1'b0;
		end
	endtask

	task automatic send_frame(input frame_kind_t kind, input int len, input int spacing,
			input int gap, input string name);
		logic [7:0]  payload[$];
		logic [7:0]  line[$];
		logic [31:0] fcs;
		logic [7:0]  pre;
		int          rnd;
		int          err_at;
		err_at = -1;
		for (int i = 0; i < len; i++) begin
			rnd = $random(seed);
			payload.push_back(rnd[7:0]);
		end
		fcs  = crc32_of(payload);
		line = payload;
		// FCS goes out low byte first
		if (kind != fk_short) begin
			line.push_back(fcs[7:0]);
			line.push_back(fcs[15:8]);
			line.push_back(fcs[23:16]);
			line.push_back(fcs[31:24]);
		end
		if (kind == fk_bad_fcs)
			line[len + rand_range(0, 3)] ^= 8'h20;
		if (kind == fk_error)
			err_at = rand_range(0, line.size() - 1);
		// Only frames that reach the SFD are counted
		case (kind)
			fk_good:                      push_expected(payload, name);
			fk_bad_fcs, fk_error, fk_short, fk_runt:
				exp_stats.frames_dropped = exp_stats.frames_dropped + 16'd1;
			default: ;
		endcase
		if (kind == fk_good)
			exp_stats.frames_ok = exp_stats.frames_ok + 16'd1;
		for (int i = 0; i < ((kind == fk_trunc) ? 4 : 7); i++) begin
			pre = (kind == fk_bad_pre && i == 3) ? 8'h5D : eth_rx_pkg::preamble_byte;
			drive_byte(1'b1, 1'b0, pre, spacing);
		end
		if (kind != fk_trunc) begin
			drive_byte(1'b1, 1'b0, eth_rx_pkg::sfd_byte, spacing);
			foreach (line[i])
				drive_byte(1'b1, (i == err_at), line[i], spacing);
		end
		for (int i = 0; i < gap; i++)
			drive_byte(1'b0, 1'b0, 8'h00, spacing);
	endtask

	// Drain the host port, then check the counters
	task automatic settle(input string name);
		while (exp_words.size() != 0)
			@(posedge gmii_rx_clk);
		repeat (40) @(posedge gmii_rx_clk);
		compare_stats(name, exp_stats, stats);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int len;
		int spacing;
		gmii_rx   = '0;
		arst_n    = 1'b0;
		exp_stats = '0;
		repeat (8) @(posedge gmii_rx_clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge gmii_rx_clk);

		// Full rate with the shortest and longest payload first
		for (int i = 0; i < full_frames; i++) begin
			len = (i == 0) ? 4 : (i == 1) ? 100 : rand_range(4, 100);
			send_frame(fk_good, len, 1, 12, "full_rate");
		end
		settle("full_rate");

		// Corrupted FCS with a good frame after each one
		for (int i = 0; i < fcs_pairs; i++) begin
			send_frame(fk_bad_fcs, rand_range(4, 100), 1, 12, "bad_fcs");
			send_frame(fk_good, rand_range(4, 100), 1, 12, "bad_fcs");
		end
		settle("bad_fcs");

		// er in data, broken preamble, short frames, truncated preamble
		// A runt carries a correct FCS over its one to three data bytes
		for (int i = 0; i < err_rounds; i++) begin
			send_frame(fk_error, rand_range(4, 100), 1, 12, "rx_errors");
			send_frame(fk_bad_pre, rand_range(4, 100), 1, 12, "rx_errors");
			send_frame(fk_short, rand_range(1, 3), 1, 12, "rx_errors");
			send_frame(fk_runt, rand_range(1, 3), 1, 12, "rx_errors");
			send_frame(fk_trunc, 0, 1, 12, "rx_errors");
			send_frame(fk_good, rand_range(4, 100), 1, 12, "rx_errors");
		end
		settle("rx_errors");

		// 100 Mbps and 10 Mbps pacing
		for (int i = 0; i < sparse_frames; i++) begin
			spacing = (rand_range(0, 1) == 0) ? 10 : 100;
			send_frame(fk_good, rand_range(4, 100), spacing, 12, "sparse_dvalid");
		end
		settle("sparse_dvalid");

		// Gapless burst of runts and long frames
		// Reader drains a word per cycle while the MAC yields one per four,
		// so neither the buffer nor the descriptor queue may overflow here
		for (int i = 0; i < burst_frames; i++) begin
			len = (i % 2 == 0) ? 4 : rand_range(4, 100);
			send_frame(fk_good, len, 1, 2, "burst");
		end
		settle("burst");

		if (error_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			abort_run();
		end
	end

	// Watchdog allows four times the worst case wire time of all tests
	initial begin
		longint limit;
		limit = longint'(full_frames + 2 * fcs_pairs + 6 * err_rounds + burst_frames)
			* max_wire_bytes;
		limit = (limit + longint'(sparse_frames) * max_wire_bytes * 100) * 4 * 100 + 100000;
		#(limit);
		$display("Watchdog expired because the DUT did not deliver every frame in time");
		abort_run();
	end

endmodule

`default_nettype wire

// ==== files.f ====
source/eth_rx_pkg.sv
source/crc32_ethernet.sv
source/gmii_rx_mac.sv
source/rx_frame_writer.sv
source/rx_frame_reader.sv
source/buffer_arbiter.sv
source/eth_rx_top.sv
test/tb_eth_rx.sv

// ==== Makefile ====
# Verilator build and run for the Ethernet receive testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_eth_rx
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator status is ignored, the log decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "STATUS: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
